// ==== verilog/kbdPs2Pkg.sv ====
// PS/2 keyboard protocol types and constants shared by the receive path
package kbdPs2Pkg;

	// ----------------------------------------
	// Scan code byte
	// ----------------------------------------

	typedef logic [7:0] scanCode; // One byte from the keyboard

	// ----------------------------------------
	// Prefix codes
	// ----------------------------------------

	// Extended key prefix for the next byte
	localparam scanCode prefixExtended = 8'hE0;

	// Break prefix that marks the next byte as a key release
	localparam scanCode prefixRelease = 8'hF0;

	// ----------------------------------------
	// Frame format
	// ----------------------------------------

	// Start, eight data bits LSB first, odd parity, stop
	localparam int ps2FrameBits = 11;

endpackage

// ==== verilog/kbdMatrixPkg.sv ====
// Key matrix geometry and coordinate types for the keyboard front end
package kbdMatrixPkg;

	// ----------------------------------------
	// Geometry
	// ----------------------------------------

	localparam int matrixRows = 11; // Rows 0-7 in bank 0, rows 8-10 in bank 1
	localparam int matrixColumns = 8; // One data bit per column

	typedef logic [3:0] rowIndex;
	typedef logic [2:0] columnIndex;

	// ----------------------------------------
	// Key coordinate
	// ----------------------------------------

	typedef struct packed {
		rowIndex    row;
		columnIndex column;
	} keyCoord;

	localparam rowIndex noKeyRow = 4'd15; // Code has no key in the matrix

	typedef logic [matrixColumns-1:0] rowData; // Column states of one row

endpackage

// ==== verilog/keyEventIf.sv ====
// Decoded key event from the scan code decoder to the key matrix
interface keyEventIf
	import kbdPs2Pkg::*;
();

	logic    strobe;   // One cycle per key event
	scanCode code;     // Scan code without prefixes
	logic    extended; // E0 seen before the code
	logic    released; // F0 seen before the code

	modport sender (
		output strobe,
		output code,
		output extended,
		output released
	);

	modport receiver (
		input strobe,
		input code,
		input extended,
		input released
	);

endinterface

// ==== verilog/ps2Receiver.sv ====
// PS/2 frame receiver with clock filter, framing check and byte strobe
module ps2Receiver
	import kbdPs2Pkg::*;
#(
	parameter int filterDepth = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    ps2Clk,
	input  logic    ps2Data,
	output logic    byteStrobe,
	output scanCode byteCode
);

	// Frame plus the preload marker bit at the bottom
	localparam int windowBits = ps2FrameBits + 1;

	logic [filterDepth-1:0] clkHistory; // Oldest sample in bit 0
	logic [windowBits-1:0]  window;
	logic [windowBits-1:0]  nextWindow;
	logic                   fallingEdge;
	logic                   frameValid;

	// ----------------------------------------
	// Edge detect and frame check
	// ----------------------------------------

	// One high sample, then filterDepth-1 low samples
	assign fallingEdge = (clkHistory == {{(filterDepth-1){1'b0}}, 1'b1});

	assign nextWindow = {ps2Data, window[windowBits-1:1]};

	// Stop high, odd parity over data and parity, start low above the marker
	assign frameValid = nextWindow[windowBits-1]
		&& (^nextWindow[windowBits-2:2])
		&& (nextWindow[1:0] == 2'b01);

	// ----------------------------------------
	// Registers
	// ----------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			clkHistory <= '1;
			window <= '1;
			byteStrobe <= 1'b0;
		end else begin
			clkHistory <= {ps2Clk, clkHistory[filterDepth-1:1]};
			byteStrobe <= fallingEdge && frameValid;
			if (fallingEdge) begin
				if (frameValid)
					window <= '1; // Rearm for the next frame
				else
					window <= nextWindow; // Keep sliding until a frame lines up
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fallingEdge)
			byteCode <= nextWindow[9:2]; // Data bits above start and marker
	end

endmodule

// ==== verilog/scanCodeDecoder.sv ====
// Scan code decoder that folds E0 and F0 prefixes into key events
module scanCodeDecoder
	import kbdPs2Pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      byteStrobe,
	input  scanCode   byteCode,
	keyEventIf.sender events
);

	logic extendedFlag; // E0 pending
	logic releaseFlag;  // F0 pending
	logic isPrefix;

	assign isPrefix = (byteCode == prefixExtended) || (byteCode == prefixRelease);

	// ----------------------------------------
	// Prefix tracking and event strobe
	// ----------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			extendedFlag <= 1'b0;
			releaseFlag <= 1'b0;
			events.strobe <= 1'b0;
		end else begin
			events.strobe <= byteStrobe && !isPrefix;
			if (byteStrobe) begin
				if (byteCode == prefixExtended) begin
					extendedFlag <= 1'b1;
				end else if (byteCode == prefixRelease) begin
					releaseFlag <= 1'b1;
				end else begin
					extendedFlag <= 1'b0; // Prefixes apply to one code only
					releaseFlag <= 1'b0;
				end
			end
		end
	end

	// Event fields that matter only in the strobe cycle
	always_ff @(posedge clk) begin
		if (byteStrobe) begin
			events.code <= byteCode;
			events.extended <= extendedFlag;
			events.released <= releaseFlag;
		end
	end

endmodule

// ==== verilog/keyMapTable.sv ====
// Keyboard layout table from scan code to key matrix coordinate
module keyMapTable
	import kbdPs2Pkg::*;
	import kbdMatrixPkg::*;
(
	input  scanCode code,
	input  logic    extended,
	output keyCoord coord
);

	function automatic keyCoord place(input rowIndex r, input columnIndex c);
		return '{row: r, column: c};
	endfunction

	always_comb begin
		case (code)
			// ----------------------------------------
			// Bank 0 with rows 0-7
			// ----------------------------------------
			8'h3C: coord = place(4'd0, 3'd0); // U
			8'h1C: coord = place(4'd0, 3'd1); // A
			8'h2C: coord = place(4'd0, 3'd2); // T
			8'h4B: coord = place(4'd0, 3'd3); // L
			8'h1D: coord = place(4'd0, 3'd4); // W
			8'h0B: coord = place(4'd0, 3'd5); // F6
			8'h2B: coord = place(4'd0, 3'd6); // F
			8'h83: coord = place(4'd0, 3'd7); // F7
			8'h3B: coord = place(4'd1, 3'd0); // J
			8'h35: coord = place(4'd1, 3'd1); // Y
			8'h2A: coord = place(4'd1, 3'd2); // V
			8'h42: coord = place(4'd1, 3'd3); // K
			8'h2D: coord = place(4'd1, 3'd4); // R
			8'h15: coord = place(4'd1, 3'd5); // Q
			8'h32: coord = place(4'd1, 3'd6); // B
			8'h54: coord = place(4'd1, 3'd7); // Left bracket
			8'h23: coord = place(4'd2, 3'd0); // D
			8'h0A: coord = place(4'd2, 3'd1); // F8
			8'h24: coord = place(4'd2, 3'd2); // E
			8'h31: coord = place(4'd2, 3'd3); // N
			8'h21: coord = place(4'd2, 3'd4); // C
			8'h33: coord = place(4'd2, 3'd5); // H
			8'h1A: coord = place(4'd2, 3'd6); // Z
			8'h34: coord = place(4'd2, 3'd7); // G
			8'h5B: coord = place(4'd3, 3'd0); // Right bracket
			8'h22: coord = place(4'd3, 3'd1); // X
			8'h44: coord = place(4'd3, 3'd2); // O
			8'h01: coord = place(4'd3, 3'd3); // F9
			8'h43: coord = place(4'd3, 3'd4); // I
			8'h4D: coord = place(4'd3, 3'd5); // P
			8'h1B: coord = place(4'd3, 3'd6); // S
			8'h3A: coord = place(4'd3, 3'd7); // M
			8'h3E: coord = place(4'd4, 3'd0); // Digit 8
			8'h3D: coord = place(4'd4, 3'd1); // Digit 7
			8'h36: coord = place(4'd4, 3'd2); // Digit 6
			8'h2E: coord = place(4'd4, 3'd3); // Digit 5
			8'h25: coord = place(4'd4, 3'd4); // Digit 4
			8'h26: coord = place(4'd4, 3'd5); // Digit 3
			8'h1E: coord = place(4'd4, 3'd6); // Digit 2
			8'h4E: coord = place(4'd4, 3'd7); // Minus
			8'h41: coord = place(4'd5, 3'd0); // Comma
			8'h4C: coord = place(4'd5, 3'd1); // Semicolon
			8'h55: coord = place(4'd5, 3'd2); // Equals
			8'h0E: coord = place(4'd5, 3'd3); // Backquote
			8'h16: coord = place(4'd5, 3'd4); // Digit 1
			8'h5D: coord = place(4'd5, 3'd5); // Backslash
			8'h45: coord = place(4'd5, 3'd6); // Digit 0
			8'h46: coord = place(4'd5, 3'd7); // Digit 9
			8'h29: coord = place(4'd6, 3'd0); // Space
			8'h0D: coord = place(4'd6, 3'd1); // Tab
			8'h66: coord = place(4'd6, 3'd2); // Backspace
			8'h7C: coord = place(4'd6, 3'd4); // Gray star
			8'h07: coord = place(4'd6, 3'd5); // F12 as stop
			8'h7B: coord = place(4'd6, 3'd6); // Gray minus
			8'h5A: coord = place(4'd6, 3'd7); // Enter
			8'h59: coord = place(4'd7, 3'd0); // Right shift
			8'h11: coord = place(4'd7, 3'd1); // Left alt
			8'h14: coord = extended ? place(4'd7, 3'd3) : place(4'd7, 3'd2); // Right or left ctrl
			8'h76: coord = place(4'd7, 3'd4); // Escape
			8'h78: coord = place(4'd7, 3'd6); // F11 as layout switch
			8'h12: coord = place(4'd7, 3'd7); // Left shift
			// ----------------------------------------
			// Bank 1 with rows 8-10
			// ----------------------------------------
			8'h6C: coord = place(4'd8, 3'd0); // Keypad 7
			8'h74: coord = place(4'd8, 3'd1); // Keypad 6
			8'h73: coord = place(4'd8, 3'd2); // Keypad 5
			8'h6B: coord = place(4'd8, 3'd3); // Keypad 4
			8'h7A: coord = place(4'd8, 3'd4); // Keypad 3
			8'h72: coord = place(4'd8, 3'd5); // Keypad 2
			8'h69: coord = place(4'd8, 3'd6); // Keypad 1
			8'h70: coord = place(4'd8, 3'd7); // Keypad 0
			8'h4A: coord = extended ? place(4'd6, 3'd3) : place(4'd9, 3'd0); // Gray or keypad slash
			8'h71: coord = place(4'd9, 3'd1); // Keypad point
			8'h52: coord = place(4'd9, 3'd2); // Apostrophe
			8'h49: coord = place(4'd9, 3'd3); // Period
			8'h7D: coord = place(4'd9, 3'd6); // Keypad 9
			8'h75: coord = place(4'd9, 3'd7); // Keypad 8
			8'h05: coord = place(4'd10, 3'd7); // F1
			8'h06: coord = place(4'd10, 3'd6); // F2
			8'h04: coord = place(4'd10, 3'd5); // F3
			8'h0C: coord = place(4'd10, 3'd4); // F4
			8'h03: coord = place(4'd10, 3'd3); // F5
			default: coord = place(noKeyRow, 3'd7);
		endcase
	end

endmodule

// ==== verilog/keyMatrix.sv ====
// Key matrix state with bank-switched multi-row read port
module keyMatrix
	import kbdMatrixPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	keyEventIf.receiver events,
	input  logic [8:0]  rowSelect,
	output rowData      readData
);

	localparam int bankRows = 8; // Rows reachable without the bank bit

	rowData  keyState [matrixRows];
	keyCoord coord;

	keyMapTable keyMap_i (
		.code     (events.code),
		.extended (events.extended),
		.coord    (coord)
	);

	// ----------------------------------------
	// Key state update
	// ----------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int r = 0; r < matrixRows; r++)
				keyState[r] <= '0;
		end else if (events.strobe && (coord.row != noKeyRow)) begin
			keyState[coord.row][coord.column] <= !events.released; // Set on make, clear on break
		end
	end

	// ----------------------------------------
	// Read port
	// ----------------------------------------

	always_comb begin
		readData = '0;
		if (rowSelect[8]) begin
			// Select lines 0-2 map to rows 8-10 in the upper bank
			for (int r = 0; r < matrixRows - bankRows; r++) begin
				if (rowSelect[r])
					readData |= keyState[r + bankRows];
			end
		end else begin
			for (int r = 0; r < bankRows; r++) begin
				if (rowSelect[r])
					readData |= keyState[r]; // Selected rows are ORed
			end
		end
	end

endmodule

// ==== verilog/kbdTop.sv ====
// Keyboard front end top level from PS/2 pins to the CPU key matrix port
module kbdTop
	import kbdPs2Pkg::*;
	import kbdMatrixPkg::*;
#(
	parameter int filterDepth = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2Clk,
	input  logic       ps2Data,
	input  logic [8:0] rowSelect,
	output rowData     readData
);

	logic    byteStrobe;
	scanCode byteCode;

	keyEventIf keyEvents ();

	ps2Receiver #(
		.filterDepth (filterDepth)
	) receiver_i (
		.clk        (clk),
		.reset      (reset),
		.ps2Clk     (ps2Clk),
		.ps2Data    (ps2Data),
		.byteStrobe (byteStrobe),
		.byteCode   (byteCode)
	);

	scanCodeDecoder decoder_i (
		.clk        (clk),
		.reset      (reset),
		.byteStrobe (byteStrobe),
		.byteCode   (byteCode),
		.events     (keyEvents.sender)
	);

	keyMatrix matrix_i (
		.clk       (clk),
		.reset     (reset),
		.events    (keyEvents.receiver),
		.rowSelect (rowSelect),
		.readData  (readData)
	);

endmodule

// ==== verification/kbdTb.sv ====
// Keyboard front end testbench with PS/2 frame driver and reference key matrix
module kbdTb
	import kbdPs2Pkg::*;
	import kbdMatrixPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int tableKeys = 10;
	localparam int strobeTimeout = 300; // A frame takes 176 cycles

	// Layout table as code, extended flag, row and column
	localparam scanCode keyCodes [tableKeys] = '{8'h1C, 8'h16, 8'h29, 8'h5A, 8'h14,
		8'h14, 8'h4A, 8'h4A, 8'h05, 8'h4C};
	localparam bit keyExt [tableKeys] = '{0, 0, 0, 0, 0, 1, 0, 1, 0, 0};
	localparam int keyRow [tableKeys] = '{0, 5, 6, 6, 7, 7, 9, 6, 10, 5};
	localparam int keyCol [tableKeys] = '{1, 4, 0, 7, 2, 3, 0, 3, 7, 1};

	logic        clk;
	logic        reset;
	logic        ps2Clk;
	logic        ps2Data;
	logic [8:0]  rowSelect;
	rowData      readData;

	rowData      refRows [matrixRows]; // Expected key state
	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          timeouts;
	int          pick;
	bit          releaseKey;

	kbdTop #(
		.filterDepth (4)
	) dut_i (
		.clk       (clk),
		.reset     (reset),
		.ps2Clk    (ps2Clk),
		.ps2Data   (ps2Data),
		.rowSelect (rowSelect),
		.readData  (readData)
	);

	always #50 clk = ~clk;

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------

	task automatic tick();
		@(posedge clk);
		#10; // Drive point after the edge
	endtask

	function automatic bit nextBit();
		bit feedback;
		feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32 22 2 1
		lfsr = {lfsr[30:0], feedback};
		return feedback;
	endfunction

	function automatic int takeBits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++)
			value = (value << 1) | nextBit();
		return value;
	endfunction

	task automatic sendFrame(input scanCode code, input bit badParity);
		logic [ps2FrameBits-1:0] bits;
		logic                    parityBit;
		parityBit = ~^code; // Odd parity
		if (badParity)
			parityBit = ~parityBit;
		bits = {1'b1, parityBit, code, 1'b0};
		for (int i = 0; i < ps2FrameBits; i++) begin
			ps2Data = bits[i]; // Data changes while the clock is high
			repeat (8) tick();
			ps2Clk = 1'b0;
			repeat (8) tick();
			ps2Clk = 1'b1;
		end
		repeat (20) tick();
	endtask

	task automatic waitEventStrobe();
		int count;
		count = 0;
		while (!dut_i.keyEvents.strobe && count < strobeTimeout) begin
			@(negedge clk);
			count++;
		end
		if (!dut_i.keyEvents.strobe) begin
			$display("Timeout at %0t: no key event came out of the decoder", $time);
			timeouts++;
		end
	endtask

	function automatic int findKey(input scanCode code, input bit ext);
		for (int i = 0; i < tableKeys; i++)
			if (keyCodes[i] == code && keyExt[i] == ext)
				return i;
		return -1; // Not in the matrix
	endfunction

	task automatic sendCode(input scanCode code, input bit ext, input bit rel, input bit badParity);
		int idx;
		if (ext)
			sendFrame(prefixExtended, 1'b0);
		if (rel)
			sendFrame(prefixRelease, 1'b0);
		if (badParity) begin
			sendFrame(code, 1'b1); // Dropped by the receiver
		end else begin
			fork
				sendFrame(code, 1'b0);
				waitEventStrobe();
			join
			idx = findKey(code, ext);
			if (idx >= 0)
				refRows[keyRow[idx]][keyCol[idx]] = !rel;
		end
	endtask

	// ----------------------------------------
	// Read checks
	// ----------------------------------------

	function automatic rowData expectedRead(input logic [8:0] sel);
		rowData acc;
		acc = '0;
		if (sel[8]) begin
			for (int r = 0; r < 3; r++)
				if (sel[r])
					acc |= refRows[r + 8]; // Bank bit shifts to rows 8-10
		end else begin
			for (int r = 0; r < 8; r++)
				if (sel[r])
					acc |= refRows[r];
		end
		return acc;
	endfunction

	task automatic checkSelect(input logic [8:0] sel);
		rowData expected;
		expected = expectedRead(sel);
		tick();
		rowSelect = sel;
		tick();
		checks++;
		assert (readData == expected)
		else begin
			$display("FAIL %0t: select %h read %h expected %h", $time, sel, readData, expected);
			errors++;
		end
	endtask

	task automatic sweepRows();
		for (int r = 0; r < matrixRows; r++) begin
			if (r < 8)
				checkSelect(9'd1 << r);
			else
				checkSelect(9'h100 | (9'd1 << (r - 8)));
		end
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		ps2Clk = 1'b1; // Idle bus
		ps2Data = 1'b1;
		rowSelect = '0;
		lfsr = 32'h9b64;
		errors = 0;
		checks = 0;
		timeouts = 0;
		for (int r = 0; r < matrixRows; r++)
			refRows[r] = '0;
		repeat (8) @(posedge clk);
		#10;
		reset = 1'b0;

		sweepRows(); // Empty after reset

		for (int i = 0; i < tableKeys; i++) begin
			sendCode(keyCodes[i], keyExt[i], 1'b0, 1'b0);
			sweepRows();
		end
		for (int i = 0; i < tableKeys; i++) begin
			sendCode(keyCodes[i], keyExt[i], 1'b1, 1'b0);
			sweepRows();
		end

		// Random press and release traffic
		for (int n = 0; n < 40; n++) begin
			pick = takeBits(4) % tableKeys;
			releaseKey = takeBits(1);
			sendCode(keyCodes[pick], keyExt[pick], releaseKey, 1'b0);
			sweepRows();
		end

		// Extended pairs
		sendCode(8'h14, 1'b0, 1'b0, 1'b0);
		sendCode(8'h14, 1'b1, 1'b0, 1'b0);
		sweepRows();
		sendCode(8'h14, 1'b1, 1'b1, 1'b0);
		sweepRows();
		sendCode(8'h4A, 1'b0, 1'b0, 1'b0);
		sendCode(8'h4A, 1'b1, 1'b0, 1'b0);
		sweepRows();
		sendCode(8'h4A, 1'b1, 1'b1, 1'b0);
		sweepRows();

		// Multi-hot reads in both banks
		sendCode(8'h1C, 1'b0, 1'b0, 1'b0);
		sendCode(8'h29, 1'b0, 1'b0, 1'b0);
		sendCode(8'h05, 1'b0, 1'b0, 1'b0);
		checkSelect(9'h0FF);
		checkSelect(9'h061);
		checkSelect(9'h0C0);
		checkSelect(9'h107);
		checkSelect(9'h106);
		checkSelect(9'h1FF); // Bits 3-7 have no rows in bank 1

		// Bad parity and unmapped code
		sendCode(8'h1C, 1'b0, 1'b1, 1'b0);
		sendCode(8'h16, 1'b0, 1'b1, 1'b0);
		sweepRows();
		sendCode(8'h1C, 1'b0, 1'b0, 1'b1);
		sweepRows();
		sendCode(8'h16, 1'b0, 1'b0, 1'b0); // Good frame right after the bad one
		sweepRows();
		sendCode(8'h0F, 1'b0, 1'b0, 1'b0);
		sweepRows();

		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/kbdPs2Pkg.sv
verilog/kbdMatrixPkg.sv
verilog/keyEventIf.sv
verilog/ps2Receiver.sv
verilog/scanCodeDecoder.sv
verilog/keyMapTable.sv
verilog/keyMatrix.sv
verilog/kbdTop.sv
verification/kbdTb.sv
